// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the FMA testbench with Verilator, run it, and judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_fma_fp16 -f sim.f -o sim_fma

./obj_dir/sim_fma | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

// ==== sim.f ====
source/fma_pkg.sv
source/fp16_unpack.sv
source/booth_multiplier.sv
source/addend_align_add.sv
source/normalize_round.sv
source/fma_fp16.sv
tb/tb_clock_gen.sv
tb/tb_fma_fp16.sv

// ==== source/addend_align_add.sv ====
// addend_align_add: shifts c against the product, signed add and magnitude recovery, second stage
module addend_align_add (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  fma_pkg::mul_stage_t stage,
    output logic                out_valid,
    output fma_pkg::sum_stage_t sum
);

    fma_pkg::align_t ext_c;
    fma_pkg::align_t shifted_c;
    logic [6:0]      shift_mag;
    logic            right_shift;  // c smaller than the product
    logic            no_add;
    logic            eff_sub;
    fma_pkg::wide_t  addend;
    fma_pkg::wide_t  raw_sum;
    fma_pkg::wide_t  magnitude;
    logic            neg;
    logic            final_sign;

    // c's hidden bit lines up with the product's integer bit at diff zero
    assign ext_c       = fma_pkg::align_t'({stage.mant_c, {fma_pkg::FRAC_W{1'b0}}});
    assign right_shift = stage.diff[6];
    assign shift_mag   = right_shift ? -stage.diff : stage.diff;
    assign shifted_c   = right_shift ? ext_c >> shift_mag : ext_c << shift_mag;
    assign no_add      = !right_shift && (stage.diff > fma_pkg::ADDEND_NO_ADD);

    assign eff_sub = stage.sign_ab ^ stage.sign_c;
    assign addend  = eff_sub ? ~{1'b0, shifted_c} : {1'b0, shifted_c};

    // carry-in finishes the two's complement of the addend
    assign raw_sum = addend + fma_pkg::wide_t'(stage.product)
                   + fma_pkg::wide_t'(eff_sub);

    assign neg       = raw_sum[$bits(fma_pkg::wide_t)-1];
    assign magnitude = neg ? ~raw_sum + 1'b1 : raw_sum;

    always_comb begin
        if (no_add)
            final_sign = stage.sign_c;
        else if (magnitude == '0)
            final_sign = stage.sign_ab & stage.sign_c;  // exact cancel gives +0
        else
            final_sign = stage.sign_ab ^ neg;
    end

    always_ff @(posedge clk) begin
        if (rst)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            sum.mag    <= magnitude;
            sum.sign   <= final_sign;
            sum.exp_ab <= stage.exp_ab;
            sum.mant_c <= stage.mant_c;
            sum.diff   <= stage.diff;
            sum.no_add <= no_add;
        end
    end

endmodule

// ==== source/booth_multiplier.sv ====
// booth_multiplier: radix-4 Booth mantissa product over a carry-save tree, first pipeline stage
module booth_multiplier (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  fma_pkg::unpacked_t  fields,
    output logic                out_valid,
    output fma_pkg::mul_stage_t stage
);

    localparam int ROW_W = 24;  // product width plus two bits of headroom
    localparam int ROWS  = 6;

    // full adder per bit, carry moved up one place
    function automatic logic [2*ROW_W-1:0] csa(
        input logic [ROW_W-1:0] x,
        input logic [ROW_W-1:0] y,
        input logic [ROW_W-1:0] z
    );
        logic [ROW_W-1:0] s;
        logic [ROW_W-1:0] cy;
        s  = x ^ y ^ z;
        cy = ((x & y) | (y & z) | (x & z)) << 1;
        return {cy, s};
    endfunction

    logic [12:0]      b_ext;       // zero below bit 0 and above bit 10
    logic [ROW_W-1:0] rows [ROWS];
    logic [ROW_W-1:0] s1, c1, s2, c2;
    logic [ROW_W-1:0] s3, c3, s4, c4;
    logic [ROW_W-1:0] csa_total;

    assign b_ext = {1'b0, fields.mant_b, 1'b0};

    // digit selection, each row two places above the last
    always_comb begin
        logic [2:0]       digit;
        logic             neg;
        logic [11:0]      mag;
        logic [ROW_W-1:0] pp;
        logic [ROW_W-1:0] fix_prev;
        fix_prev = '0;
        for (int i = 0; i < ROWS; i++) begin
            digit = b_ext[2*i +: 3];
            case (digit)
                3'b001, 3'b010: begin  // +1
                    mag = {1'b0, fields.mant_a};
                    neg = 1'b0;
                end
                3'b011: begin          // +2
                    mag = {fields.mant_a, 1'b0};
                    neg = 1'b0;
                end
                3'b100: begin          // -2
                    mag = {fields.mant_a, 1'b0};
                    neg = 1'b1;
                end
                3'b101, 3'b110: begin  // -1
                    mag = {1'b0, fields.mant_a};
                    neg = 1'b1;
                end
                default: begin
                    mag = '0;
                    neg = 1'b0;
                end
            endcase
            pp = {{(ROW_W-12){1'b0}}, mag};
            if (neg)
                pp = ~pp;  // ones complement, the +1 rides in the next row
            // low bits of this row are free for the previous correction bit
            rows[i]  = (pp << (2*i)) | fix_prev;
            fix_prev = ROW_W'(neg) << (2*i);
        end
    end

    // three levels of 3:2 reduction
    assign {c1, s1} = csa(rows[0], rows[1], rows[2]);
    assign {c2, s2} = csa(rows[3], rows[4], rows[5]);
    assign {c3, s3} = csa(s1, c1, s2);
    assign {c4, s4} = csa(s3, c3, c2);

    assign csa_total = s4 + c4;

    always_ff @(posedge clk) begin
        if (rst)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            stage.sign_ab <= fields.sign_ab;
            stage.sign_c  <= fields.sign_c;
            stage.exp_ab  <= fields.exp_ab;
            stage.diff    <= fields.diff;
            stage.mant_c  <= fields.mant_c;
            stage.product <= fma_pkg::prod_t'(csa_total);
        end
    end

    // sign extension of negative rows must cancel out of the headroom bits
    assert property (@(posedge clk) disable iff (rst)
        in_valid |-> csa_total[ROW_W-1:$bits(fma_pkg::prod_t)] == '0);

endmodule

// ==== source/fma_fp16.sv ====
// fma_fp16: three-stage pipelined half-precision fused multiply-add, result = a*b + c
module fma_fp16 (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  fma_pkg::fp16_t a,
    input  fma_pkg::fp16_t b,
    input  fma_pkg::fp16_t c,
    output logic           out_valid,
    output fma_pkg::fp16_t result
);

    fma_pkg::unpacked_t  fields;
    logic                mul_valid;
    fma_pkg::mul_stage_t mul_stage;
    logic                sum_valid;
    fma_pkg::sum_stage_t sum_stage;

    // combinational front end
    fp16_unpack u_unpack (
        .a      (a),
        .b      (b),
        .c      (c),
        .fields (fields)
    );

    // stage 1
    booth_multiplier u_mul (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .fields    (fields),
        .out_valid (mul_valid),
        .stage     (mul_stage)
    );

    // stage 2
    addend_align_add u_add (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (mul_valid),
        .stage     (mul_stage),
        .out_valid (sum_valid),
        .sum       (sum_stage)
    );

    // stage 3
    normalize_round u_round (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (sum_valid),
        .sum       (sum_stage),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

// ==== source/fma_pkg.sv ====
// fma_pkg: FP16 field types, internal datapath widths and pipeline stage records
package fma_pkg;

    // format constants
    localparam int EXP_BIAS      = 15;
    localparam int EXP_MIN       = -14;  // smallest normal exponent, also subnormal exponent
    localparam int ADDEND_NO_ADD = 13;   // beyond this c swamps the product
    localparam int FRAC_W        = 10;

    typedef logic [15:0]        fp16_t;
    typedef logic [10:0]        mant_t;   // hidden bit plus fraction
    typedef logic signed [5:0]  exp_t;    // unbiased exponent
    typedef logic signed [6:0]  diff_t;   // c exponent minus product exponent, -44..43
    typedef logic [21:0]        prod_t;
    typedef logic [34:0]        wide_t;   // aligned sum, top bit is the sign before recovery
    typedef logic [33:0]        align_t;
    typedef logic [5:0]         shift_t;

    // operands split into fields, combinational out of the unpacker
    typedef struct packed {
        logic  sign_ab;
        logic  sign_c;
        exp_t  exp_ab;
        diff_t diff;
        mant_t mant_a;
        mant_t mant_b;
        mant_t mant_c;
    } unpacked_t;

    // stage 1 register
    typedef struct packed {
        logic  sign_ab;
        logic  sign_c;
        exp_t  exp_ab;
        diff_t diff;
        mant_t mant_c;
        prod_t product;
    } mul_stage_t;

    // stage 2 register
    typedef struct packed {
        wide_t mag;
        logic  sign;     // final sign of the result
        exp_t  exp_ab;
        mant_t mant_c;
        diff_t diff;
        logic  no_add;   // result is c unchanged
    } sum_stage_t;

endpackage

// ==== source/fp16_unpack.sv ====
// fp16_unpack: splits the three operands and forms product sign, exponent and alignment distance
module fp16_unpack (
    input  fma_pkg::fp16_t     a,
    input  fma_pkg::fp16_t     b,
    input  fma_pkg::fp16_t     c,
    output fma_pkg::unpacked_t fields
);

    // subnormals sit at EXP_MIN with a clear hidden bit
    function automatic fma_pkg::exp_t true_exp(input fma_pkg::fp16_t x);
        logic [4:0] field;
        field = x[14:fma_pkg::FRAC_W];
        if (field == '0)
            return fma_pkg::exp_t'(fma_pkg::EXP_MIN);
        return fma_pkg::exp_t'($signed({1'b0, field}) - fma_pkg::EXP_BIAS);
    endfunction

    function automatic fma_pkg::mant_t hidden_mant(input fma_pkg::fp16_t x);
        return {|x[14:fma_pkg::FRAC_W], x[fma_pkg::FRAC_W-1:0]};
    endfunction

    fma_pkg::exp_t exp_a;
    fma_pkg::exp_t exp_b;
    fma_pkg::exp_t exp_c;
    fma_pkg::exp_t exp_ab;

    assign exp_a  = true_exp(a);
    assign exp_b  = true_exp(b);
    assign exp_c  = true_exp(c);
    assign exp_ab = exp_a + exp_b;  // -28..30, fits six bits

    always_comb begin
        fields.sign_ab = a[15] ^ b[15];
        fields.sign_c  = c[15];
        fields.exp_ab  = exp_ab;
        // seven bits, the difference can reach 43 either way
        fields.diff    = {exp_c[5], exp_c} - {exp_ab[5], exp_ab};
        fields.mant_a  = hidden_mant(a);
        fields.mant_b  = hidden_mant(b);
        fields.mant_c  = hidden_mant(c);
    end

endmodule

// ==== source/normalize_round.sv ====
// normalize_round: leading-zero normalization, subnormal clamp, round to nearest even and pack
module normalize_round (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  fma_pkg::sum_stage_t sum,
    output logic                out_valid,
    output fma_pkg::fp16_t      result
);

    localparam int TOP     = $bits(fma_pkg::wide_t) - 1;
    localparam int MANT_W  = $bits(fma_pkg::mant_t);
    localparam int GRD_POS = TOP - MANT_W;
    // bit 2*FRAC_W of the sum carries weight 2^exp_ab
    localparam int TOP_OFFSET = TOP - 2 * fma_pkg::FRAC_W;

    fma_pkg::shift_t   lz;
    fma_pkg::shift_t   shamt;
    logic signed [7:0] exp_ab8;
    logic signed [7:0] diff8;
    logic signed [7:0] exp_offset;
    logic signed [7:0] exp_norm;
    logic signed [7:0] exp_clamp;
    logic signed [7:0] exp_pre;
    logic signed [7:0] exp_final;
    fma_pkg::wide_t    shifted;
    fma_pkg::mant_t    man;
    fma_pkg::mant_t    rounded;
    logic              guard;
    logic              round_bit;
    logic              sticky;
    logic              round_up;
    logic              carry;
    logic [4:0]        exp_field;
    fma_pkg::fp16_t    packed_result;

    assign exp_ab8 = $signed({{2{sum.exp_ab[5]}}, sum.exp_ab});
    assign diff8   = $signed({sum.diff[6], sum.diff});

    // priority leading-zero count, highest set bit wins
    always_comb begin
        lz = 6'd35;  // zero magnitude
        for (int i = 0; i <= TOP; i++) begin
            if (sum.mag[i])
                lz = fma_pkg::shift_t'(TOP - i);
        end
        exp_offset = 8'(TOP_OFFSET) - $signed({2'b00, lz});
    end

    assign exp_norm = exp_ab8 + exp_offset;

    // below EXP_MIN the shift stops where bit TOP weighs 2^EXP_MIN
    always_comb begin
        if (exp_norm < fma_pkg::EXP_MIN) begin
            shamt     = fma_pkg::shift_t'(exp_ab8 + TOP_OFFSET - fma_pkg::EXP_MIN);
            exp_clamp = 8'(fma_pkg::EXP_MIN);
        end else begin
            shamt     = lz;
            exp_clamp = exp_norm;
        end
    end

    assign shifted = sum.mag << shamt;

    always_comb begin
        if (sum.no_add) begin
            man       = sum.mant_c;
            guard     = 1'b0;
            round_bit = 1'b0;
            sticky    = 1'b0;
            exp_pre   = exp_ab8 + diff8;  // back to c's exponent
        end else begin
            man       = shifted[TOP -: MANT_W];
            guard     = shifted[GRD_POS];
            round_bit = shifted[GRD_POS-1];
            sticky    = |shifted[GRD_POS-2:0];
            exp_pre   = exp_clamp;
        end
    end

    // ties go to the even neighbour
    assign round_up = guard & (round_bit | sticky | man[0]);

    always_comb begin
        {carry, rounded} = {1'b0, man} + (MANT_W + 1)'(round_up);
        exp_final        = exp_pre;
        if (carry) begin
            rounded   = fma_pkg::mant_t'(1) << fma_pkg::FRAC_W;  // 10.0 becomes 1.0
            exp_final = exp_pre + 8'sd1;
        end
    end

    // clear hidden bit means a subnormal or zero field
    assign exp_field = rounded[fma_pkg::FRAC_W] ?
                       5'(exp_final + fma_pkg::EXP_BIAS) : 5'd0;
    assign packed_result = {sum.sign, exp_field, rounded[fma_pkg::FRAC_W-1:0]};

    always_ff @(posedge clk) begin
        if (rst)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (in_valid)
            result <= packed_result;
    end

    // every valid operand set must leave the pipe fully resolved
    assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !$isunknown(result));

endmodule

// ==== tb/fma_testdata.hex ====
// columns: a b c expected, FP16 hex words, expected = round_nearest_even(a*b + c)
// exact products with c zero
3c00 3c00 0000 3c00
4200 4200 0000 4880
4000 3eaa 0000 42aa
3e00 3e80 0000 40e0
4200 3c02 0000 4203
c200 4200 0000 c880
// add, subtract, cancellation and sign flip
3c00 3c00 3c00 4000
4000 4200 c500 3c00
3c01 3c00 bc00 1400
3c00 3c00 c200 c000
c000 4200 4580 b800
4000 4200 c600 0000
4500 4700 3800 5070
c500 c700 b800 5050
3c00 3c00 9000 3bff
// ties to even, sticky and rounding carry
3c00 3c00 1000 3c00
3c01 3c00 1000 3c02
4200 3c01 0000 4202
4200 3c03 0000 4204
4200 3fff 0000 45ff
3c00 3c00 1100 3c01
3fff 3c00 1000 4000
// subnormal operands and results
0200 4000 0000 0400
0400 3800 0000 0200
0001 3800 0000 0000
0003 3800 0000 0002
0001 3c00 0001 0002
03ff 3c00 0001 0400
3c01 3c01 bc02 0010
8200 4000 0000 8400
// addend far above the product
3c00 3c00 7400 7400
3c00 3c00 f400 f400
4200 3e00 7555 7555

// ==== tb/tb_clock_gen.sv ====
// tb_clock_gen: free-running 4 ns clock and a reset held over the first two rising edges
module tb_clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;  // released between edges
    end

endmodule

// ==== tb/tb_fma_fp16.sv ====
// tb_fma_fp16: file-driven testbench for the pipelined FP16 fused multiply-add
module tb_fma_fp16;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_VECTORS = 64;
    localparam int LATENCY     = 3;

    logic           clk;
    logic           rst;
    logic           in_valid;
    fma_pkg::fp16_t a;
    fma_pkg::fp16_t b;
    fma_pkg::fp16_t c;
    logic           out_valid;
    fma_pkg::fp16_t result;

    fma_pkg::fp16_t words [4*MAX_VECTORS];  // a, b, c, expected per vector
    fma_pkg::fp16_t exp_q [$];
    logic [LATENCY-1:0] in_hist;            // in_valid of the last three drives
    logic [31:0]    lfsr;
    logic           loaded;
    int             num_vectors;

    tb_clock_gen clock_gen (
        .clk (clk),
        .rst (rst)
    );

    fma_fp16 UUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .c         (c),
        .out_valid (out_valid),
        .result    (result)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic check_result(input fma_pkg::fp16_t got, input fma_pkg::fp16_t expected);
        if (got !== expected) begin
            $display("Error at %0d ns: result got %h expected %h", $time, got, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_valid(input logic got, input logic expected);
        if (got !== expected) begin
            $display("Error at %0d ns: out_valid got %b expected %b", $time, got, expected);
            stop_with_failure();
        end
    endtask

    // outputs settle after the rising edge, so the falling edge sees them stable
    task automatic check_outputs();
        check_valid(out_valid, in_hist[LATENCY-1]);
        if (out_valid)
            check_result(result, exp_q.pop_front());
    endtask

    task automatic drive_cycle(input logic valid, input fma_pkg::fp16_t va,
                               input fma_pkg::fp16_t vb, input fma_pkg::fp16_t vc);
        @(negedge clk);
        check_outputs();
        in_valid = valid;
        a        = va;
        b        = vb;
        c        = vc;
        in_hist  = {in_hist[LATENCY-2:0], valid};
    endtask

    // unread slots get an all-ones exponent, which no finite operand has
    task automatic load_vectors();
        for (int i = 0; i < 4*MAX_VECTORS; i++)
            words[i] = {6'b011111, 10'(i)};
        $readmemh("tb/fma_testdata.hex", words);
        num_vectors = 0;
        while (num_vectors < MAX_VECTORS && words[4*num_vectors][14:10] != 5'h1f)
            num_vectors++;
    endtask

    initial begin : watchdog
        int limit;
        wait (loaded === 1'b1);
        limit = 2 * num_vectors + 10;  // worst case is one idle cycle per vector
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not end within %0d clock cycles", limit);
        stop_with_failure();
    end

    initial begin
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        c        = '0;
        in_hist  = '0;
        lfsr     = 32'ha9b09a66;
        loaded   = 1'b0;
        load_vectors();
        if (num_vectors == 0) begin
            $display("no test vectors found in tb/fma_testdata.hex");
            stop_with_failure();
        end else begin
            loaded = 1'b1;
            @(negedge rst);
            for (int i = 0; i < num_vectors; i++) begin
                drive_cycle(1'b1, words[4*i], words[4*i+1], words[4*i+2]);
                exp_q.push_back(words[4*i+3]);
                lfsr = lfsr_next(lfsr);
                if (lfsr[0] && i < num_vectors - 1)
                    drive_cycle(1'b0, '0, '0, '0);  // idle gap
            end
            // drain the pipe, then make sure nothing extra comes out
            while (exp_q.size() != 0)
                drive_cycle(1'b0, '0, '0, '0);
            repeat (LATENCY) drive_cycle(1'b0, '0, '0, '0);
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule
